// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= camera_tb
RTL_TOP     ?= camera_top
FILE_LIST   ?= tb.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing

FAIL_TEXT   := FAIL: see errors above
PASS_TEXT   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/bayer_metering.sv ====
`timescale 1ns/1ps
`include "camera_params.svh"

module bayer_metering
    import camera_pixel_pkg::*;
#(
    parameter int WINDOW_SIZE = `CAMERA_CENTER_WINDOW
) (
    input  logic   mipi_byte_clock,
    input  logic   mipi_byte_reset_n,

    input  pixel_t pixel_i,
    input  logic   line_valid_i,
    input  logic   frame_valid_i,

    input  coord_t width_i,
    input  coord_t height_i,

    output meter_t red_o,
    output meter_t green_o,
    output meter_t blue_o,
    output logic   meter_valid_o
);

    localparam int     WINDOW_LOG2 = $clog2(WINDOW_SIZE);
    localparam int     SUM_WIDTH   = `CAMERA_PIXEL_WIDTH + 2 * WINDOW_LOG2;
    localparam coord_t WINDOW      = coord_t'(WINDOW_SIZE);

    meter_state_e           state;
    bayer_color_e           color;
    coord_t                 x_count;
    coord_t                 y_count;
    coord_t                 x_offset;
    coord_t                 y_offset;
    logic                   line_valid_q;
    logic                   in_window;
    logic [SUM_WIDTH-1:0]   pixel_wide;
    logic [SUM_WIDTH-1:0]   red_add;
    logic [SUM_WIDTH-1:0]   green_add;
    logic [SUM_WIDTH-1:0]   blue_add;
    logic [SUM_WIDTH-1:0]   red_sum;
    logic [SUM_WIDTH-1:0]   green_sum;
    logic [SUM_WIDTH-1:0]   blue_sum;

    assign x_offset = (width_i - WINDOW) >> 1;  // Centered in the crop
    assign y_offset = (height_i - WINDOW) >> 1;

    assign in_window = line_valid_i &&
                       (x_count >= x_offset) && (x_count < x_offset + WINDOW) &&
                       (y_count >= y_offset) && (y_count < y_offset + WINDOW);

    assign color      = bayer_color_e'({y_count[0], x_count[0]});
    assign pixel_wide = {{(SUM_WIDTH - `CAMERA_PIXEL_WIDTH){1'b0}}, pixel_i};

    always_comb begin
        red_add   = '0;
        green_add = '0;
        blue_add  = '0;
        if (in_window) begin
            case (color)
                red:              red_add   = pixel_wide;
                green_r, green_b: green_add = pixel_wide;
                blue:             blue_add  = pixel_wide;
                default:          red_add   = '0;
            endcase
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count      <= '0;
            y_count      <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;
            x_count      <= line_valid_i ? x_count + 1'b1 : '0;
            if (!frame_valid_i) begin
                y_count <= '0;
            end else if (line_valid_q && !line_valid_i) begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    // Red and blue each cover a quarter of the window, green half of it
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state         <= wait_frame;
            red_sum       <= '0;
            green_sum     <= '0;
            blue_sum      <= '0;
            red_o         <= '0;
            green_o       <= '0;
            blue_o        <= '0;
            meter_valid_o <= 1'b0;
        end else begin
            meter_valid_o <= 1'b0;
            case (state)
                wait_frame: begin
                    red_sum   <= red_add;  // Fresh start, may hold the first pixel
                    green_sum <= green_add;
                    blue_sum  <= blue_add;
                    if (frame_valid_i) begin
                        state <= accumulate;
                    end
                end
                accumulate: begin
                    red_sum   <= red_sum + red_add;
                    green_sum <= green_sum + green_add;
                    blue_sum  <= blue_sum + blue_add;
                    if (!frame_valid_i) begin
                        red_o         <= red_sum[2 * WINDOW_LOG2 +: `CAMERA_METER_WIDTH];
                        green_o       <= green_sum[2 * WINDOW_LOG2 + 1 +: `CAMERA_METER_WIDTH];
                        blue_o        <= blue_sum[2 * WINDOW_LOG2 +: `CAMERA_METER_WIDTH];
                        meter_valid_o <= 1'b1;
                        state         <= wait_frame;
                    end
                end
                default: state <= wait_frame;
            endcase
        end
    end

endmodule

// ==== hw/camera_apb_pkg.sv ====
`include "camera_params.svh"

package camera_apb_pkg;

    typedef logic [`CAMERA_APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [`CAMERA_APB_DATA_WIDTH-1:0] apb_data_t;

    // Byte offsets of the register map
    typedef enum logic [`CAMERA_APB_ADDR_WIDTH-1:0] {
        crop_x_start  = 8'h00,
        crop_x_end    = 8'h04,
        crop_y_start  = 8'h08,
        crop_y_end    = 8'h0C,
        center_meter  = 8'h10,  // Read only from here on
        average_meter = 8'h14,
        brightness    = 8'h18,
        frame_count   = 8'h1C
    } camera_reg_e;

endpackage

// ==== hw/camera_apb_regs.sv ====
`timescale 1ns/1ps
`include "camera_params.svh"

module camera_apb_regs
    import camera_pixel_pkg::*;
    import camera_apb_pkg::*;
(
    input  logic      mipi_byte_clock,
    input  logic      mipi_byte_reset_n,

    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,

    output coord_t    x_start_o,
    output coord_t    x_end_o,
    output coord_t    y_start_o,
    output coord_t    y_end_o,

    input  meter_t    center_red_i,
    input  meter_t    center_green_i,
    input  meter_t    center_blue_i,
    input  meter_t    average_red_i,
    input  meter_t    average_green_i,
    input  meter_t    average_blue_i,
    input  logic      meter_valid_i
);

    localparam int     TRIPLET_WIDTH = 3 * `CAMERA_METER_WIDTH;
    localparam int     SUM_WIDTH     = `CAMERA_METER_WIDTH + 3;  // Six values
    localparam coord_t DEFAULT_END   = coord_t'(`CAMERA_AVERAGE_WINDOW);

    logic [TRIPLET_WIDTH-1:0] center_q;
    logic [TRIPLET_WIDTH-1:0] average_q;
    logic [SUM_WIDTH-1:0]     meter_sum;
    meter_t                   brightness_q;
    apb_data_t                frame_count_q;
    camera_reg_e              reg_sel;
    logic                     access;

    assign access    = psel_i && penable_i;
    assign reg_sel   = camera_reg_e'(paddr_i);
    assign pready_o  = access;  // No wait states
    assign pslverr_o = 1'b0;

    assign meter_sum = SUM_WIDTH'(center_red_i) + SUM_WIDTH'(center_green_i) +
                       SUM_WIDTH'(center_blue_i) + SUM_WIDTH'(average_red_i) +
                       SUM_WIDTH'(average_green_i) + SUM_WIDTH'(average_blue_i);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_start_o     <= '0;
            x_end_o       <= DEFAULT_END;
            y_start_o     <= '0;
            y_end_o       <= DEFAULT_END;
            center_q      <= '0;
            average_q     <= '0;
            brightness_q  <= '0;
            frame_count_q <= '0;
        end else begin
            if (access && pwrite_i) begin
                case (reg_sel)
                    crop_x_start: x_start_o <= pwdata_i[`CAMERA_COORD_WIDTH-1:0];
                    crop_x_end:   x_end_o   <= pwdata_i[`CAMERA_COORD_WIDTH-1:0];
                    crop_y_start: y_start_o <= pwdata_i[`CAMERA_COORD_WIDTH-1:0];
                    crop_y_end:   y_end_o   <= pwdata_i[`CAMERA_COORD_WIDTH-1:0];
                    default: ;  // Read only or unmapped
                endcase
            end

            if (meter_valid_i) begin
                center_q      <= {center_red_i, center_green_i, center_blue_i};
                average_q     <= {average_red_i, average_green_i, average_blue_i};
                brightness_q  <= meter_t'(meter_sum / SUM_WIDTH'(6));
                frame_count_q <= frame_count_q + 1'b1;
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            case (reg_sel)
                crop_x_start:  prdata_o = apb_data_t'(x_start_o);
                crop_x_end:    prdata_o = apb_data_t'(x_end_o);
                crop_y_start:  prdata_o = apb_data_t'(y_start_o);
                crop_y_end:    prdata_o = apb_data_t'(y_end_o);
                center_meter:  prdata_o = apb_data_t'(center_q);
                average_meter: prdata_o = apb_data_t'(average_q);
                brightness:    prdata_o = apb_data_t'(brightness_q);
                frame_count:   prdata_o = frame_count_q;
                default:       prdata_o = '0;
            endcase
        end
    end

endmodule

// ==== hw/camera_params.svh ====
`ifndef CAMERA_PARAMS_SVH
`define CAMERA_PARAMS_SVH

// Raw Bayer pixel from the byte to pixel stage
`define CAMERA_PIXEL_WIDTH 10

// One colour channel of a metering result
`define CAMERA_METER_WIDTH 8

`define CAMERA_COORD_WIDTH 12

`define CAMERA_APB_ADDR_WIDTH 8
`define CAMERA_APB_DATA_WIDTH 32

// Metering window sides, powers of two
`define CAMERA_CENTER_WINDOW 16
`define CAMERA_AVERAGE_WINDOW 64

`endif

// ==== hw/camera_pixel_pkg.sv ====
`include "camera_params.svh"

package camera_pixel_pkg;

    typedef logic [`CAMERA_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`CAMERA_COORD_WIDTH-1:0] coord_t;
    typedef logic [`CAMERA_METER_WIDTH-1:0] meter_t;

    // Encoded as {row parity, column parity} of an RGGB site
    typedef enum logic [1:0] {
        red     = 2'b00,
        green_r = 2'b01,
        green_b = 2'b10,
        blue    = 2'b11
    } bayer_color_e;

    typedef enum logic {
        wait_frame,
        accumulate
    } meter_state_e;

endpackage

// ==== hw/camera_top.sv ====
`timescale 1ns/1ps
`include "camera_params.svh"

module camera_top
    import camera_pixel_pkg::*;
    import camera_apb_pkg::*;
(
    input  logic      mipi_byte_clock,
    input  logic      mipi_byte_reset_n,

    input  pixel_t    pixel_i,
    input  logic      line_valid_i,
    input  logic      frame_valid_i,

    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    coord_t x_start;
    coord_t x_end;
    coord_t y_start;
    coord_t y_end;
    coord_t crop_width;
    coord_t crop_height;

    pixel_t cropped_pixel;
    logic   cropped_line_valid;
    logic   cropped_frame_valid;

    meter_t center_red;
    meter_t center_green;
    meter_t center_blue;
    meter_t average_red;
    meter_t average_green;
    meter_t average_blue;
    logic   center_valid;

    // Crop applies the same even rounding to the starts
    assign crop_width  = x_end - {x_start[`CAMERA_COORD_WIDTH-1:1], 1'b0};
    assign crop_height = y_end - {y_start[`CAMERA_COORD_WIDTH-1:1], 1'b0};

    pixel_crop pan_crop (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel_i),
        .line_valid_i      (line_valid_i),
        .frame_valid_i     (frame_valid_i),
        .x_start_i         (x_start),
        .x_end_i           (x_end),
        .y_start_i         (y_start),
        .y_end_i           (y_end),
        .pixel_o           (cropped_pixel),
        .line_valid_o      (cropped_line_valid),
        .frame_valid_o     (cropped_frame_valid)
    );

    bayer_metering #(
        .WINDOW_SIZE (`CAMERA_CENTER_WINDOW)
    ) center_metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (cropped_pixel),
        .line_valid_i      (cropped_line_valid),
        .frame_valid_i     (cropped_frame_valid),
        .width_i           (crop_width),
        .height_i          (crop_height),
        .red_o             (center_red),
        .green_o           (center_green),
        .blue_o            (center_blue),
        .meter_valid_o     (center_valid)
    );

    bayer_metering #(
        .WINDOW_SIZE (`CAMERA_AVERAGE_WINDOW)
    ) average_metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (cropped_pixel),
        .line_valid_i      (cropped_line_valid),
        .frame_valid_i     (cropped_frame_valid),
        .width_i           (crop_width),
        .height_i          (crop_height),
        .red_o             (average_red),
        .green_o           (average_green),
        .blue_o            (average_blue),
        .meter_valid_o     ()  // Pulses with center_valid
    );

    camera_apb_regs apb_regs (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .paddr_i           (paddr_i),
        .psel_i            (psel_i),
        .penable_i         (penable_i),
        .pwrite_i          (pwrite_i),
        .pwdata_i          (pwdata_i),
        .prdata_o          (prdata_o),
        .pready_o          (pready_o),
        .pslverr_o         (pslverr_o),
        .x_start_o         (x_start),
        .x_end_o           (x_end),
        .y_start_o         (y_start),
        .y_end_o           (y_end),
        .center_red_i      (center_red),
        .center_green_i    (center_green),
        .center_blue_i     (center_blue),
        .average_red_i     (average_red),
        .average_green_i   (average_green),
        .average_blue_i    (average_blue),
        .meter_valid_i     (center_valid)
    );

endmodule

// ==== hw/pixel_crop.sv ====
`timescale 1ns/1ps
`include "camera_params.svh"

module pixel_crop
    import camera_pixel_pkg::*;
(
    input  logic   mipi_byte_clock,
    input  logic   mipi_byte_reset_n,

    input  pixel_t pixel_i,
    input  logic   line_valid_i,
    input  logic   frame_valid_i,

    input  coord_t x_start_i,
    input  coord_t x_end_i,
    input  coord_t y_start_i,
    input  coord_t y_end_i,

    output pixel_t pixel_o,
    output logic   line_valid_o,
    output logic   frame_valid_o
);

    coord_t x_count;
    coord_t y_count;
    coord_t x_first;
    coord_t y_first;
    logic   line_valid_q;
    logic   in_window;

    // Even start keeps the RGGB phase
    assign x_first = {x_start_i[`CAMERA_COORD_WIDTH-1:1], 1'b0};
    assign y_first = {y_start_i[`CAMERA_COORD_WIDTH-1:1], 1'b0};

    assign in_window = line_valid_i &&
                       (x_count >= x_first) && (x_count < x_end_i) &&
                       (y_count >= y_first) && (y_count < y_end_i);

    // Position of the pixel currently on pixel_i
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count      <= '0;
            y_count      <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;

            if (line_valid_i) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;  // Restart for next line
            end

            if (!frame_valid_i) begin
                y_count <= '0;
            end else if (line_valid_q && !line_valid_i) begin
                y_count <= y_count + 1'b1;  // End of a line
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            line_valid_o  <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            line_valid_o  <= in_window;
            frame_valid_o <= frame_valid_i;  // Same delay as the pixels
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        pixel_o <= pixel_i;
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/camera_pixel_pkg.sv
hw/camera_apb_pkg.sv
hw/pixel_crop.sv
hw/bayer_metering.sv
hw/camera_apb_regs.sv
hw/camera_top.sv
verification/camera_checker.sv
verification/camera_scoreboard.sv
verification/camera_tb.sv

// ==== verification/camera_checker.sv ====
`timescale 1ns/1ps

module camera_checker (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,
    input logic line_valid_i,
    input logic frame_valid_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic meter_valid_i
);

    int failure_count = 0;

    line_in_frame: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        line_valid_i |-> frame_valid_i)
    else begin
        $error("line_valid high while frame_valid is low");
        failure_count++;
    end

    ready_in_access: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        (psel_i && penable_i) |-> pready_i)
    else begin
        $error("pready low during an APB access phase");
        failure_count++;
    end

    meter_pulse: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        meter_valid_i |=> !meter_valid_i)
    else begin
        $error("meter_valid held for more than one cycle");
        failure_count++;
    end

endmodule

bind camera_top camera_checker protocol_checks (
    .mipi_byte_clock       (mipi_byte_clock),
    .mipi_byte_reset_n     (mipi_byte_reset_n),
    .line_valid_i          (line_valid_i),
    .frame_valid_i         (frame_valid_i),
    .psel_i                (psel_i),
    .penable_i             (penable_i),
    .pready_i              (pready_o),
    .meter_valid_i         (center_valid)
);

// ==== verification/camera_scoreboard.sv ====
`timescale 1ns/1ps

module camera_scoreboard
    import camera_apb_pkg::*;
(
    input  logic      mipi_byte_clock,
    input  logic      mipi_byte_reset_n,
    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  logic      pready_i,
    input  logic      pslverr_i,
    input  apb_data_t prdata_i
);

    apb_addr_t addr_q [$];
    apb_data_t data_q [$];
    string     test_name;
    int        test_count  = 0;
    int        test_errors = 0;
    int        check_count = 0;
    int        error_count = 0;

    task automatic expect_read(input apb_addr_t addr, input apb_data_t data);
        addr_q.push_back(addr);
        data_q.push_back(data);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (addr_q.size() != 0) begin
            $display("Test %s ended with %0d expected reads never seen on the bus",
                     test_name, addr_q.size());
            test_errors += addr_q.size();
            error_count += addr_q.size();
            addr_q.delete();
            data_q.delete();
        end
        test_count++;
        if (test_errors == 0) begin
            $display("Test %0d %s: passed", test_count, test_name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", test_count, test_name, test_errors);
        end
    endtask

    // Sampled on the edge that closes the access phase
    always @(posedge mipi_byte_clock) begin
        apb_addr_t expected_addr;
        apb_data_t expected_data;
        if (mipi_byte_reset_n && psel_i && penable_i && pready_i && pslverr_i) begin
            $display("FAILED at time %0t: pslverr high on access to 0x%02h", $time, paddr_i);
            test_errors++;
            error_count++;
        end
        if (mipi_byte_reset_n && psel_i && penable_i && pready_i && !pwrite_i) begin
            if (addr_q.size() == 0) begin
                $display("Unexpected APB read of address 0x%02h", paddr_i);
                test_errors++;
                error_count++;
            end else begin
                expected_addr = addr_q.pop_front();
                expected_data = data_q.pop_front();
                check_count++;
                if (expected_addr != paddr_i) begin
                    $display("APB read of address 0x%02h arrived while 0x%02h was expected",
                             paddr_i, expected_addr);
                    test_errors++;
                    error_count++;
                end else if (prdata_i !== expected_data) begin
                    $display("FAILED at time %0t: read of 0x%02h returned 0x%08h, expected 0x%08h",
                             $time, paddr_i, prdata_i, expected_data);
                    test_errors++;
                    error_count++;
                end
            end
        end
    end

endmodule

// ==== verification/camera_tb.sv ====
`timescale 1ns/1ps
`include "camera_params.svh"

module camera_tb
    import camera_pixel_pkg::*;
    import camera_apb_pkg::*;
();

    localparam int     CLOCK_PERIOD   = 8;
    localparam int     LINE_BLANK     = 4;
    localparam int     FRAME_BLANK    = 6;
    localparam int     MAX_WIDTH      = 96;
    localparam int     MAX_HEIGHT     = 80;
    localparam int     FRAME_TOTAL    = 3;
    localparam int     FRAME_CYCLES   = MAX_HEIGHT * (MAX_WIDTH + LINE_BLANK) + 2 * FRAME_BLANK;
    localparam int     TIMEOUT_CYCLES = FRAME_TOTAL * FRAME_CYCLES + 2000;  // Reset and APB traffic
    localparam pixel_t RED_LEVEL      = 10'h200;
    localparam pixel_t GREEN_LEVEL    = 10'h155;
    localparam pixel_t BLUE_LEVEL     = 10'h3FC;

    logic      mipi_byte_clock;
    logic      mipi_byte_reset_n;
    pixel_t    pixel;
    logic      line_valid;
    logic      frame_valid;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    pixel_t    frame_mem [MAX_HEIGHT][MAX_WIDTH];
    apb_data_t center_expected;
    apb_data_t average_expected;
    apb_data_t brightness_expected;
    int        frames_sent;

    camera_top i_camera_top (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel),
        .line_valid_i      (line_valid),
        .frame_valid_i     (frame_valid),
        .paddr_i           (paddr),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .pwdata_i          (pwdata),
        .prdata_o          (prdata),
        .pready_o          (pready),
        .pslverr_o         (pslverr)
    );

    camera_scoreboard checks (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .paddr_i           (paddr),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .pready_i          (pready),
        .pslverr_i         (pslverr),
        .prdata_i          (prdata)
    );

    always #(CLOCK_PERIOD / 2) mipi_byte_clock = ~mipi_byte_clock;

    // Averages of the centered window inside a crop, packed as in the register
    function automatic apb_data_t reference_meter(input int window, input int x_start,
                                                  input int x_end, input int y_start,
                                                  input int y_end);
        int     x_first;
        int     y_first;
        int     x_offset;
        int     y_offset;
        int     row;
        int     col;
        int     value;
        int     red_sum;
        int     green_sum;
        int     blue_sum;
        int     red_count;
        int     green_count;
        int     blue_count;
        meter_t red8;
        meter_t green8;
        meter_t blue8;
        x_first     = x_start - (x_start % 2);  // Bit 0 of a start is ignored
        y_first     = y_start - (y_start % 2);
        x_offset    = (x_end - x_first - window) / 2;
        y_offset    = (y_end - y_first - window) / 2;
        red_sum     = 0;
        green_sum   = 0;
        blue_sum    = 0;
        red_count   = 0;
        green_count = 0;
        blue_count  = 0;
        for (row = y_offset; row < y_offset + window; row++) begin
            for (col = x_offset; col < x_offset + window; col++) begin
                value = int'(frame_mem[y_first + row][x_first + col]);
                if (row % 2 == 0 && col % 2 == 0) begin
                    red_sum += value;
                    red_count++;
                end else if (row % 2 == 1 && col % 2 == 1) begin
                    blue_sum += value;
                    blue_count++;
                end else begin
                    green_sum += value;
                    green_count++;
                end
            end
        end
        // Top 8 of the 10-bit average
        red8   = meter_t'((red_sum / red_count) / 4);
        green8 = meter_t'((green_sum / green_count) / 4);
        blue8  = meter_t'((blue_sum / blue_count) / 4);
        return {8'h00, red8, green8, blue8};
    endfunction

    function automatic apb_data_t reference_brightness(input apb_data_t center,
                                                       input apb_data_t average);
        int total;
        total = int'(center[23:16]) + int'(center[15:8]) + int'(center[7:0]) +
                int'(average[23:16]) + int'(average[15:8]) + int'(average[7:0]);
        return apb_data_t'(total / 6);
    endfunction

    task automatic fill_constant(input int width, input int height);
        int row;
        int col;
        for (row = 0; row < height; row++) begin
            for (col = 0; col < width; col++) begin
                if (row % 2 == 0 && col % 2 == 0) begin
                    frame_mem[row][col] = RED_LEVEL;
                end else if (row % 2 == 1 && col % 2 == 1) begin
                    frame_mem[row][col] = BLUE_LEVEL;
                end else begin
                    frame_mem[row][col] = GREEN_LEVEL;
                end
            end
        end
    endtask

    task automatic fill_random(input int width, input int height);
        int row;
        int col;
        for (row = 0; row < height; row++) begin
            for (col = 0; col < width; col++) begin
                frame_mem[row][col] = pixel_t'($urandom);
            end
        end
    endtask

    task automatic send_frame(input int width, input int height);
        int row;
        int col;
        @(negedge mipi_byte_clock);
        frame_valid = 1'b1;
        repeat (FRAME_BLANK) @(negedge mipi_byte_clock);
        for (row = 0; row < height; row++) begin
            for (col = 0; col < width; col++) begin
                line_valid = 1'b1;
                pixel      = frame_mem[row][col];
                @(negedge mipi_byte_clock);
            end
            line_valid = 1'b0;
            pixel      = '0;
            repeat (LINE_BLANK) @(negedge mipi_byte_clock);
        end
        frame_valid = 1'b0;
        repeat (3) @(posedge mipi_byte_clock);  // Crop, latch, register store
        frames_sent++;
    endtask

    task automatic wait_ready();
        do begin
            @(posedge mipi_byte_clock);
        end while (!pready);
        @(negedge mipi_byte_clock);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(negedge mipi_byte_clock);
        paddr  = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel   = 1'b1;
        @(negedge mipi_byte_clock);
        penable = 1'b1;
        wait_ready();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr);
        @(negedge mipi_byte_clock);
        paddr  = addr;
        pwrite = 1'b0;
        psel   = 1'b1;
        @(negedge mipi_byte_clock);
        penable = 1'b1;
        wait_ready();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_and_expect(input apb_addr_t addr, input apb_data_t expected);
        checks.expect_read(addr, expected);
        apb_read(addr);
    endtask

    task automatic read_results();
        read_and_expect(center_meter, center_expected);
        read_and_expect(average_meter, average_expected);
        read_and_expect(brightness, brightness_expected);
        read_and_expect(frame_count, apb_data_t'(frames_sent));
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(15295));
        mipi_byte_clock   = 1'b0;
        mipi_byte_reset_n = 1'b0;
        pixel             = '0;
        line_valid        = 1'b0;
        frame_valid       = 1'b0;
        paddr             = '0;
        psel              = 1'b0;
        penable           = 1'b0;
        pwrite            = 1'b0;
        pwdata            = '0;
        frames_sent       = 0;
        repeat (3) @(posedge mipi_byte_clock);
        @(negedge mipi_byte_clock);
        mipi_byte_reset_n = 1'b1;

        checks.start_test("reset defaults");
        read_and_expect(crop_x_start, 32'd0);
        read_and_expect(crop_x_end, 32'd64);
        read_and_expect(crop_y_start, 32'd0);
        read_and_expect(crop_y_end, 32'd64);
        center_expected     = '0;
        average_expected    = '0;
        brightness_expected = '0;
        read_results();
        checks.finish_test();

        checks.start_test("constant colour frame");
        fill_constant(64, 64);
        send_frame(64, 64);
        center_expected     = {8'h00, meter_t'(RED_LEVEL >> 2), meter_t'(GREEN_LEVEL >> 2),
                               meter_t'(BLUE_LEVEL >> 2)};
        average_expected    = center_expected;  // Whole crop is one colour pattern
        brightness_expected = reference_brightness(center_expected, average_expected);
        read_results();
        checks.finish_test();

        checks.start_test("random frame with pan crop");
        apb_write(crop_x_start, 32'd16);
        apb_write(crop_x_end, 32'd80);
        apb_write(crop_y_start, 32'd8);
        apb_write(crop_y_end, 32'd72);
        read_and_expect(crop_x_start, 32'd16);
        read_and_expect(crop_y_end, 32'd72);
        fill_random(MAX_WIDTH, MAX_HEIGHT);
        send_frame(MAX_WIDTH, MAX_HEIGHT);
        center_expected     = reference_meter(`CAMERA_CENTER_WINDOW, 16, 80, 8, 72);
        average_expected    = reference_meter(`CAMERA_AVERAGE_WINDOW, 16, 80, 8, 72);
        brightness_expected = reference_brightness(center_expected, average_expected);
        read_results();
        checks.finish_test();

        checks.start_test("odd crop start");
        apb_write(crop_x_start, 32'd21);
        apb_write(crop_x_end, 32'd84);
        apb_write(crop_y_start, 32'd5);
        apb_write(crop_y_end, 32'd68);
        read_and_expect(crop_x_start, 32'd21);  // Register keeps the raw value
        read_and_expect(crop_y_start, 32'd5);
        fill_random(MAX_WIDTH, MAX_HEIGHT);
        send_frame(MAX_WIDTH, MAX_HEIGHT);
        center_expected     = reference_meter(`CAMERA_CENTER_WINDOW, 21, 84, 5, 68);
        average_expected    = reference_meter(`CAMERA_AVERAGE_WINDOW, 21, 84, 5, 68);
        brightness_expected = reference_brightness(center_expected, average_expected);
        read_results();
        checks.finish_test();

        checks.start_test("read-only registers and frame count");
        apb_write(center_meter, 32'hFFFF_FFFF);
        apb_write(average_meter, 32'hFFFF_FFFF);
        apb_write(brightness, 32'hFFFF_FFFF);
        apb_write(frame_count, 32'hFFFF_FFFF);
        read_results();
        read_and_expect(frame_count, apb_data_t'(FRAME_TOTAL));
        checks.finish_test();

        $display("Tests: %0d, reads checked: %0d, errors: %0d, assertion failures: %0d",
                 checks.test_count, checks.check_count, checks.error_count,
                 i_camera_top.protocol_checks.failure_count);
        if (checks.error_count == 0 && i_camera_top.protocol_checks.failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
